//--- src.f
+incdir+include
rtl/lab_types_pkg.sv
rtl/lab_ctrl_pkg.sv
rtl/slow_clk_gen.sv
rtl/key_cond.sv
rtl/bcd_counter.sv
rtl/seven_seg_scan.sv
rtl/lab_top.sv
rtl/board_specific_top.sv
bench/tb_board.sv

//--- Bender.yml
package:
  name: lab_stopwatch

sources:
  - include_dirs:
      - include
    files:
      - rtl/lab_types_pkg.sv
      - rtl/lab_ctrl_pkg.sv
      - rtl/slow_clk_gen.sv
      - rtl/key_cond.sv
      - rtl/bcd_counter.sv
      - rtl/seven_seg_scan.sv
      - rtl/lab_top.sv
      - rtl/board_specific_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - bench/tb_board.sv

//--- bench/tb_board.sv
`default_nettype none

`include "lab_params.svh"

module tb_board;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_mhz    = 1;
    localparam int slow_hz    = 100000;
    localparam int half_cyc   = clk_mhz * 1000000 / (2 * slow_hz);
    localparam int tick_per   = 2 * half_cyc;
    localparam int first_tick = half_cyc + 1;    // slow_clk rises after edge half_cyc-1, sync adds one.
    localparam int deb        = `LAB_DEBOUNCE_CYCLES;
    localparam int hold_cyc   = deb + 4;
    localparam int scan_limit = 4 * `LAB_SCAN_CYCLES;

    logic                     clkin_50;
    logic                     clkin_125;
    logic                     clkin_sma;
    logic                     clkout_sma;
    logic                     cpu_resetn;
    logic [`LAB_W_KEY-1:0]    user_pb;
    logic [`LAB_W_SW-1:0]     user_dipsw;
    wire  [`LAB_W_LED-1:0]    user_led;
    wire  [7:0]               seg_pins;          // a in bit 7, dp in bit 0.
    wire                      seven_seg_minus;
    wire  [`LAB_W_DIGIT:1]    seven_seg_sel;
    wire                      speaker_out;

    int                        cyc;               // rising edges since reset was released.
    int                        key_due [3];       // edge at which each key press takes effect.
    logic [15:0]               m_count;
    lab_ctrl_pkg::ctrl_state_t m_state;
    int                        m_ticks;
    logic [3:0]                shown [`LAB_W_DIGIT];
    int                        seen_at [`LAB_W_DIGIT];

    board_specific_top #(
        .clk_mhz     (clk_mhz),
        .slow_clk_hz (slow_hz)
    ) i_dut (
        .clkin_50        (clkin_50),
        .clkin_125       (clkin_125),
        .clkin_sma       (clkin_sma),
        .clkout_sma      (clkout_sma),
        .cpu_resetn      (cpu_resetn),
        .user_pb         (user_pb),
        .user_dipsw      (user_dipsw),
        .user_led        (user_led),
        .seven_seg_a     (seg_pins[7]),
        .seven_seg_b     (seg_pins[6]),
        .seven_seg_c     (seg_pins[5]),
        .seven_seg_d     (seg_pins[4]),
        .seven_seg_e     (seg_pins[3]),
        .seven_seg_f     (seg_pins[2]),
        .seven_seg_g     (seg_pins[1]),
        .seven_seg_dp    (seg_pins[0]),
        .seven_seg_minus (seven_seg_minus),
        .seven_seg_sel   (seven_seg_sel),
        .speaker_out     (speaker_out)
    );

    initial begin
        clkin_50 = 1'b0;
        forever #10 clkin_50 = ~clkin_50;
    end

    function automatic int to_int(input logic [15:0] bcd);
        return bcd[15:12] * 1000 + bcd[11:8] * 100 + bcd[7:4] * 10 + bcd[3:0];
    endfunction

    function automatic logic [15:0] to_bcd(input int n);
        return {4'(n / 1000 % 10), 4'(n / 100 % 10), 4'(n / 10 % 10), 4'(n % 10)};
    endfunction

    function automatic bit is_tick(input int c);
        return (c >= first_tick) && ((c - first_tick) % tick_per == 0);
    endfunction

    // Standard seven-segment codes with a in the MSB; anything else reads as 15.
    function automatic logic [3:0] seg_to_bcd(input logic [7:0] segs);
        case (segs)
            8'hfc:   return 4'd0;
            8'h60:   return 4'd1;
            8'hda:   return 4'd2;
            8'hf2:   return 4'd3;
            8'h66:   return 4'd4;
            8'hb6:   return 4'd5;
            8'hbe:   return 4'd6;
            8'he0:   return 4'd7;
            8'hfe:   return 4'd8;
            8'hf6:   return 4'd9;
            default: return 4'hf;
        endcase
    endfunction

    task automatic check_value(input string name, input int expected, input int actual);
        if (expected !== actual) begin
            $display("error: %s expected %0h actual %0h", name, expected, actual);
            $display("*** FAILED ***");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    task automatic fail_timeout(input string what);
        $display("timeout: %s", what);
        $display("*** FAILED ***");
        $fatal(1, "timeout");
    endtask

    // The reference model takes one step per rising edge and applies clear before load
    // before start/stop before tick.
    always @(posedge clkin_50) begin
        if (!cpu_resetn) begin
            cyc     = 0;
            m_count = '0;
            m_state = lab_ctrl_pkg::st_idle;
            m_ticks = 0;
        end else begin
            if (key_due[1] == cyc) begin
                m_count = '0;
                m_state = lab_ctrl_pkg::st_idle;
            end else if (key_due[2] == cyc) begin
                m_count = {8'h00, user_dipsw};
                m_state = lab_ctrl_pkg::st_hold;
            end else if (key_due[0] == cyc) begin
                m_state = (m_state == lab_ctrl_pkg::st_run) ? lab_ctrl_pkg::st_hold
                                                            : lab_ctrl_pkg::st_run;
            end else if (is_tick(cyc) && m_state == lab_ctrl_pkg::st_run) begin
                m_count = to_bcd((to_int(m_count) + 1) % 10000);
                m_ticks++;
            end
            cyc++;
        end
    end

    // Pin monitor; the rightmost digit sits on the highest select pin.
    always @(negedge clkin_50) begin
        if (cyc > 0) begin
            check_value("leds follow count", m_count[7:0], {24'h0, ~user_led});
            check_value("one digit selected", 1, $countones(~seven_seg_sel));
            check_value("minus segment dark", 1, seven_seg_minus);
            check_value("speaker silent", 0, speaker_out);
            for (int i = 1; i <= `LAB_W_DIGIT; i++) begin
                if (!seven_seg_sel[i]) begin
                    shown[`LAB_W_DIGIT - i]   = seg_to_bcd(~seg_pins);
                    seen_at[`LAB_W_DIGIT - i] = cyc;
                end
            end
        end
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clkin_50);
    endtask

    task automatic press_key(input int k);
        key_due[k] = cyc + deb + 2;    // two synchronizer flops, the debounce and the command edge.
        user_pb[k] = 1'b0;
        wait_cycles(hold_cyc);
        user_pb[k] = 1'b1;
        wait_cycles(hold_cyc);
    endtask

    task automatic wait_ticks(input int n);
        int goal;
        int waited;
        goal   = m_ticks + n;
        waited = 0;
        while (m_ticks < goal) begin
            if (waited > (n + 1) * tick_per + deb) begin
                fail_timeout("the counter did not advance on the slow clock");
            end
            waited++;
            @(negedge clkin_50);
        end
    endtask

    // Presses stop so that the last tick before it lands on the target count.
    task automatic stop_at(input logic [15:0] target);
        int pending;
        int waited;
        waited = 0;
        forever begin
            pending = 0;
            for (int c = cyc; c <= cyc + deb + 1; c++) begin
                pending += is_tick(c);
            end
            if (to_bcd((to_int(m_count) + pending) % 10000) == target) begin
                break;
            end
            if (waited > 10000 * tick_per) begin
                fail_timeout("the count never approached the stop target");
            end
            waited++;
            @(negedge clkin_50);
        end
        press_key(0);
    endtask

    task automatic check_display(input string name, input logic [15:0] expected);
        int start;
        int waited;
        start  = cyc;
        waited = 0;
        @(posedge clkin_50);
        while (seen_at[0] <= start || seen_at[1] <= start ||
               seen_at[2] <= start || seen_at[3] <= start) begin
            if (waited > scan_limit) begin
                fail_timeout("not every display digit was refreshed in time");
            end
            waited++;
            @(posedge clkin_50);
        end
        for (int d = 0; d < `LAB_W_DIGIT; d++) begin
            check_value(name, expected[d*4 +: 4], shown[d]);
        end
        @(negedge clkin_50);
    endtask

    task automatic set_switches();
        logic [7:0] r;
        r = 8'($urandom);
        if (r[3:0] > 4'd9) begin
            r[3:0] = 4'd9;
        end
        if (r[7:4] > 4'd9) begin
            r[7:4] = 4'd9;
        end
        user_dipsw = r;
    endtask

    initial begin
        int op;
        void'($urandom(32'hac1f_1d87));
        clkin_125  = 1'b0;
        clkin_sma  = 1'b0;
        clkout_sma = 1'b0;
        cpu_resetn = 1'b0;
        user_pb    = '1;
        user_dipsw = '0;
        for (int k = 0; k < 3; k++) begin
            key_due[k] = -1;
        end
        repeat (3) @(posedge clkin_50);
        @(negedge clkin_50);
        cpu_resetn = 1'b1;

        wait_cycles(3 * tick_per);
        check_display("idle after reset", 16'h0000);

        for (int n = 0; n < 9; n++) begin
            op = (n < 3) ? n : $urandom % 3;
            case (op)
                0: begin
                    set_switches();
                    press_key(2);
                    check_display("load", {8'h00, user_dipsw});
                    wait_cycles(3 * tick_per);
                    check_display("hold after load", {8'h00, user_dipsw});
                end
                1: begin
                    press_key(0);
                    wait_ticks(1 + $urandom % 25);
                    press_key(0);
                    check_display("run and stop", m_count);
                end
                default: begin
                    press_key(0);
                    wait_ticks(1 + $urandom % 6);
                    press_key(1);
                    check_display("clear during run", 16'h0000);
                    wait_cycles(3 * tick_per);
                    check_display("idle after clear", 16'h0000);
                end
            endcase
        end

        press_key(1);
        user_dipsw = 8'h98;
        press_key(2);
        press_key(0);
        stop_at(16'h9998);
        check_display("set up 9998", 16'h9998);
        press_key(0);
        stop_at(16'h0005);
        check_display("after wrap", 16'h0005);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/board_specific_top.sv
`default_nettype none

`include "lab_params.svh"

module board_specific_top #(
    parameter int unsigned clk_mhz     = `LAB_CLK_MHZ,
    parameter int unsigned slow_clk_hz = 1
) (
    input  wire                      clkin_50,
    input  wire                      clkin_125,
    input  wire                      clkin_sma,
    input  wire                      clkout_sma,

    input  wire                      cpu_resetn,

    input  wire  [`LAB_W_KEY-1:0]    user_pb,
    input  wire  [`LAB_W_SW-1:0]     user_dipsw,
    output logic [`LAB_W_LED-1:0]    user_led,

    output logic                     seven_seg_a,
    output logic                     seven_seg_b,
    output logic                     seven_seg_c,
    output logic                     seven_seg_d,
    output logic                     seven_seg_e,
    output logic                     seven_seg_f,
    output logic                     seven_seg_g,
    output logic                     seven_seg_dp,
    output logic                     seven_seg_minus,

    output logic [`LAB_W_DIGIT:1]    seven_seg_sel,

    output logic                     speaker_out
);

    logic                      clk;
    logic                      rst_n;
    logic                      slow_clk;
    lab_types_pkg::led_t       led;
    lab_types_pkg::segs_t      abcdefgh;
    lab_types_pkg::digit_sel_t digit;

    assign clk   = clkin_50;      // the other board clocks stay unconnected.
    assign rst_n = cpu_resetn;

    assign seven_seg_minus = 1'b1;    // segment pins are active low, so this keeps it dark.
    assign speaker_out     = 1'b0;

    assign user_led = ~led;

    assign {seven_seg_a, seven_seg_b, seven_seg_c, seven_seg_d,
            seven_seg_e, seven_seg_f, seven_seg_g, seven_seg_dp} = ~abcdefgh;

    // The leftmost select pin drives the highest digit and the pins are active low.
    assign seven_seg_sel = ~{<<{digit}};

    slow_clk_gen #(
        .fast_clk_mhz (clk_mhz),
        .slow_clk_hz  (slow_clk_hz)
    ) i_slow_clk_gen (
        .clk      (clk),
        .rst_n    (rst_n),
        .slow_clk (slow_clk)
    );

    lab_top i_lab_top (
        .clk      (clk),
        .rst_n    (rst_n),
        .slow_clk (slow_clk),
        .key      (~user_pb),
        .sw       (user_dipsw),
        .led      (led),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

`default_nettype wire

//--- rtl/lab_top.sv
`default_nettype none

module lab_top (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          slow_clk,
    input  var lab_types_pkg::key_t      key,
    input  var lab_types_pkg::sw_t       sw,
    output lab_types_pkg::led_t          led,
    output lab_types_pkg::segs_t         abcdefgh,
    output lab_types_pkg::digit_sel_t    digit
);

    lab_types_pkg::key_t        press;
    logic                       slow_q;
    logic                       slow_prev;
    logic                       tick;
    lab_ctrl_pkg::ctrl_state_t  state;
    lab_ctrl_pkg::ctrl_state_t  next_state;
    lab_ctrl_pkg::cnt_cmd_t     cmd;
    lab_types_pkg::count_t      load_value;
    lab_types_pkg::count_t      count;

    function automatic lab_types_pkg::bcd_t clamp_bcd(input logic [3:0] nibble);
        return (nibble > 4'd9) ? 4'd9 : nibble;
    endfunction

    key_cond i_key_cond (
        .clk   (clk),
        .rst_n (rst_n),
        .key   (key),
        .press (press)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            slow_q    <= 1'b0;
            slow_prev <= 1'b0;
            state     <= lab_ctrl_pkg::st_idle;
        end else begin
            slow_q    <= slow_clk;    // slow_clk is a level here and never a clock.
            slow_prev <= slow_q;
            state     <= next_state;
        end
    end

    assign tick = slow_q & ~slow_prev;

    // Clear wins over load, load over start/stop, and start/stop over a tick.
    always_comb begin
        next_state = state;
        cmd        = lab_ctrl_pkg::cmd_none;
        if (press[1]) begin
            cmd        = lab_ctrl_pkg::cmd_clear;
            next_state = lab_ctrl_pkg::st_idle;
        end else if (press[2]) begin
            cmd        = lab_ctrl_pkg::cmd_load;
            next_state = lab_ctrl_pkg::st_hold;
        end else if (press[0]) begin
            next_state = (state == lab_ctrl_pkg::st_run) ? lab_ctrl_pkg::st_hold
                                                         : lab_ctrl_pkg::st_run;
        end else if (tick && state == lab_ctrl_pkg::st_run) begin
            cmd = lab_ctrl_pkg::cmd_inc;
        end
    end

    always_comb begin
        load_value      = '0;
        load_value[3:0] = clamp_bcd(sw[3:0]);   // switch nibbles above 9 saturate at 9.
        load_value[7:4] = clamp_bcd(sw[7:4]);
    end

    bcd_counter i_bcd_counter (
        .clk        (clk),
        .rst_n      (rst_n),
        .cmd        (cmd),
        .load_value (load_value),
        .count      (count)
    );

    assign led = count[7:0];

    seven_seg_scan i_seven_seg_scan (
        .clk      (clk),
        .rst_n    (rst_n),
        .count    (count),
        .abcdefgh (abcdefgh),
        .digit    (digit)
    );

endmodule

`default_nettype wire

//--- rtl/seven_seg_scan.sv
`default_nettype none

`include "lab_params.svh"

module seven_seg_scan (
    input  wire                          clk,
    input  wire                          rst_n,
    input  var lab_types_pkg::count_t    count,
    output lab_types_pkg::segs_t         abcdefgh,
    output lab_types_pkg::digit_sel_t    digit
);

    localparam int unsigned n_digits    = `LAB_W_DIGIT;
    localparam int unsigned scan_cycles = `LAB_SCAN_CYCLES;
    localparam int unsigned scan_w      = (scan_cycles > 1) ? $clog2(scan_cycles) : 1;

    logic [scan_w-1:0]         scan_cnt;
    logic                      advance;
    lab_types_pkg::digit_sel_t next_sel;
    lab_types_pkg::bcd_t       next_bcd;

    assign advance  = (scan_cnt == scan_w'(scan_cycles - 1));
    assign next_sel = advance ? {digit[n_digits-2:0], digit[n_digits-1]} : digit;

    always_comb begin
        next_bcd = '0;
        for (int d = 0; d < n_digits; d++) begin
            if (next_sel[d]) begin
                next_bcd = count[d*4 +: 4];
            end
        end
    end

    function automatic lab_types_pkg::segs_t decode_bcd(input lab_types_pkg::bcd_t value);
        case (value)
            4'd0:    return 8'hfc;
            4'd1:    return 8'h60;
            4'd2:    return 8'hda;
            4'd3:    return 8'hf2;
            4'd4:    return 8'h66;
            4'd5:    return 8'hb6;
            4'd6:    return 8'hbe;
            4'd7:    return 8'he0;
            4'd8:    return 8'hfe;
            4'd9:    return 8'hf6;
            default: return 8'h02;   // a lone middle bar marks a bad digit.
        endcase
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            scan_cnt <= '0;
            digit    <= lab_types_pkg::digit_sel_t'(1);
        end else begin
            scan_cnt <= advance ? '0 : scan_cnt + 1'b1;
            digit    <= next_sel;
        end
    end

    // Segments follow the select of the same edge, so no digit shows a neighbour's value.
    always_ff @(posedge clk) begin
        abcdefgh <= decode_bcd(next_bcd);
    end

    a_digit_onehot : assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(digit))
        else $error("digit select is not one-hot");

endmodule

`default_nettype wire

//--- rtl/bcd_counter.sv
`default_nettype none

`include "lab_params.svh"

module bcd_counter (
    input  wire                          clk,
    input  wire                          rst_n,
    input  var lab_ctrl_pkg::cnt_cmd_t   cmd,
    input  var lab_types_pkg::count_t    load_value,
    output lab_types_pkg::count_t        count
);

    localparam int unsigned n_digits = `LAB_W_DIGIT;

    lab_types_pkg::count_t inc_value;
    lab_types_pkg::bcd_t   digit_cur;
    logic                  carry;

    // Decimal ripple; a digit that passes 9 returns to 0 and carries on.
    always_comb begin
        carry     = 1'b1;
        digit_cur = '0;
        inc_value = count;
        for (int d = 0; d < n_digits; d++) begin
            digit_cur = count[d*4 +: 4];
            if (carry) begin
                if (digit_cur == 4'd9) begin
                    inc_value[d*4 +: 4] = 4'd0;
                end else begin
                    inc_value[d*4 +: 4] = digit_cur + 4'd1;
                    carry               = 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= '0;
        end else begin
            case (cmd)
                lab_ctrl_pkg::cmd_inc:   count <= inc_value;
                lab_ctrl_pkg::cmd_clear: count <= '0;
                lab_ctrl_pkg::cmd_load:  count <= load_value;
                default:                 count <= count;
            endcase
        end
    end

    function automatic logic digits_valid(input lab_types_pkg::count_t value);
        logic ok;
        ok = 1'b1;
        for (int d = 0; d < n_digits; d++) begin
            if (value[d*4 +: 4] > 4'd9) begin
                ok = 1'b0;
            end
        end
        return ok;
    endfunction

    a_digits_bcd : assert property (@(posedge clk) disable iff (!rst_n)
        digits_valid(count))
        else $error("count holds a digit above 9");

endmodule

`default_nettype wire

//--- rtl/key_cond.sv
`default_nettype none

`include "lab_params.svh"

module key_cond (
    input  wire                     clk,
    input  wire                     rst_n,
    input  var lab_types_pkg::key_t key,
    output lab_types_pkg::key_t     press
);

    localparam int unsigned n_keys     = `LAB_W_KEY;
    localparam int unsigned deb_cycles = `LAB_DEBOUNCE_CYCLES;
    localparam int unsigned cnt_w      = (deb_cycles > 1) ? $clog2(deb_cycles) : 1;

    lab_types_pkg::key_t sync_q1;
    lab_types_pkg::key_t sync_q2;
    lab_types_pkg::key_t level;                      // last accepted level of each key.
    logic [cnt_w-1:0]    stable_cnt [n_keys];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sync_q1 <= '0;
            sync_q2 <= '0;
            level   <= '0;
            press   <= '0;
            for (int i = 0; i < n_keys; i++) begin
                stable_cnt[i] <= '0;
            end
        end else begin
            sync_q1 <= key;
            sync_q2 <= sync_q1;
            for (int i = 0; i < n_keys; i++) begin
                press[i] <= 1'b0;
                if (sync_q2[i] == level[i]) begin
                    stable_cnt[i] <= '0;                // a bounce restarts the wait.
                end else if (stable_cnt[i] == cnt_w'(deb_cycles - 1)) begin
                    stable_cnt[i] <= '0;
                    level[i]      <= sync_q2[i];
                    press[i]      <= sync_q2[i];        // only the rising level counts.
                end else begin
                    stable_cnt[i] <= stable_cnt[i] + 1'b1;
                end
            end
        end
    end

    a_press_pulse : assert property (@(posedge clk) disable iff (!rst_n)
        (press & $past(press)) == '0)
        else $error("press stayed high for more than one cycle");

endmodule

`default_nettype wire

//--- rtl/slow_clk_gen.sv
`default_nettype none

`include "lab_params.svh"

module slow_clk_gen #(
    parameter int unsigned fast_clk_mhz = `LAB_CLK_MHZ,
    parameter int unsigned slow_clk_hz  = 1
) (
    input  wire  clk,
    input  wire  rst_n,
    output logic slow_clk
);

    localparam int unsigned half_period = fast_clk_mhz * 1000000 / (2 * slow_clk_hz);
    localparam int unsigned cnt_w       = (half_period > 1) ? $clog2(half_period) : 1;
    localparam logic [cnt_w-1:0] reload = cnt_w'(half_period - 1);

    logic [cnt_w-1:0] cnt;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt      <= reload;
            slow_clk <= 1'b0;
        end else if (cnt == '0) begin
            cnt      <= reload;     // a new half period starts here.
            slow_clk <= ~slow_clk;
        end else begin
            cnt <= cnt - 1'b1;
        end
    end

    a_level_holds : assert property (@(posedge clk) disable iff (!rst_n)
        (cnt != '0) |=> $stable(slow_clk))
        else $error("slow_clk changed in the middle of a half period");

endmodule

`default_nettype wire

//--- rtl/lab_ctrl_pkg.sv
`default_nettype none

package lab_ctrl_pkg;

    typedef enum logic [1:0] {
        st_idle = 2'd0,  // count cleared and stopped.
        st_run  = 2'd1,  // count advances on every tick.
        st_hold = 2'd2   // count frozen at a nonzero or loaded value.
    } ctrl_state_t;

    typedef enum logic [1:0] {
        cmd_none  = 2'd0,
        cmd_inc   = 2'd1,
        cmd_clear = 2'd2,
        cmd_load  = 2'd3
    } cnt_cmd_t;

endpackage

`default_nettype wire

//--- rtl/lab_types_pkg.sv
`default_nettype none

`include "lab_params.svh"

package lab_types_pkg;

    typedef logic [`LAB_W_KEY-1:0]   key_t;       // one bit per push button.
    typedef logic [`LAB_W_SW-1:0]    sw_t;        // one bit per DIP switch.
    typedef logic [`LAB_W_LED-1:0]   led_t;       // one bit per LED.

    typedef logic [3:0]                bcd_t;     // a single decimal digit.
    typedef logic [4*`LAB_W_DIGIT-1:0] count_t;   // digit 0 sits in the low nibble.

    // Segments a to g and the decimal point, active high, with a in the MSB.
    typedef logic [7:0] segs_t;

    // One-hot digit select, active high, with bit 0 as the rightmost digit.
    typedef logic [`LAB_W_DIGIT-1:0] digit_sel_t;

endpackage

`default_nettype wire

//--- include/lab_params.svh
`ifndef LAB_PARAMS_SVH
`define LAB_PARAMS_SVH

// Board clock rate in MHz.
`define LAB_CLK_MHZ 50

`define LAB_W_KEY   4
`define LAB_W_SW    8
`define LAB_W_LED   8
`define LAB_W_DIGIT 4

// Cycles a synchronized key level must hold before it is accepted.
`define LAB_DEBOUNCE_CYCLES 16

// Cycles each display digit stays selected.
`define LAB_SCAN_CYCLES 32

`endif
